// File: design/booth_lane.sv
`default_nettype none

module booth_lane (
	input logic clk,
	input logic rst,
	booth_lane_if.lane bus
);

	localparam int unsigned part_w = mul_cfg_pkg::part_w;
	localparam int unsigned mcand_w = mul_cfg_pkg::mcand_w;
	localparam int unsigned mplier_w = mul_cfg_pkg::mplier_w;
	localparam int unsigned recode_w = mul_cfg_pkg::recode_w;
	localparam logic [mul_cfg_pkg::step_cnt_w-1:0] last_step =
		mul_cfg_pkg::step_cnt_w'(mul_cfg_pkg::booth_steps - 1);

	logic busy;
	logic done_q;
	logic load;
	logic [mul_cfg_pkg::step_cnt_w-1:0] cnt;
	// running sum, shifted multiplicand, recoding window
	logic [part_w-1:0] acc;
	logic [part_w-1:0] mc;
	logic [recode_w-1:0] mp;
	logic [part_w-1:0] pp;

	assign load = bus.start & ~bus.flush;

	// ************************************************************
	// radix-4 recoding of the low three window bits
	// ************************************************************
	always_comb begin
		case (mp[2:0])
			3'b001, 3'b010: pp = mc;
			3'b011: pp = mc << 1;
			3'b100: pp = -(mc << 1);
			3'b101, 3'b110: pp = -mc;
			// 000 and 111
			default: pp = '0;
		endcase
	end

	// control
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done_q <= 1'b0;
			cnt <= '0;
		end else begin
			done_q <= 1'b0;
			if (bus.flush) begin
				// abort, no done for this one
				busy <= 1'b0;
				cnt <= '0;
			end else if (bus.start) begin
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == last_step) begin
					busy <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (load) begin
			acc <= '0;
			mc <= {{(part_w-mcand_w){bus.mcand[mcand_w-1]}}, bus.mcand};
			// spare sign bit on top, implicit zero below bit 0
			mp <= {bus.mplier[mplier_w-1], bus.mplier, 1'b0};
		end else if (busy) begin
			acc <= acc + pp;
			// weight of the next digit is 4x
			mc <= mc << 2;
			mp <= {{2{mp[recode_w-1]}}, mp[recode_w-1:2]};
		end
	end

	assign bus.partial = acc;
	assign bus.done = done_q;

endmodule

`default_nettype wire

// File: design/booth_lane_if.sv
`default_nettype none

interface booth_lane_if;

	// one-cycle kick, operands must be valid with it
	logic start;
	// abort whatever the lane is doing
	logic flush;
	logic [mul_cfg_pkg::mcand_w-1:0] mcand;
	logic [mul_cfg_pkg::mplier_w-1:0] mplier;

	// lane result, valid while done is high
	logic [mul_cfg_pkg::part_w-1:0] partial;
	logic done;

	// operand front end
	modport front (output start, flush, mcand, mplier);

	// booth engine
	modport lane (input start, flush, mcand, mplier, output partial, done);

	// result combiner, also watches flush
	modport sink (input partial, done, flush);

endinterface

`default_nettype wire

// File: design/booth_multiplier.sv
`default_nettype none

module booth_multiplier (
	input logic clk,
	input logic rst,
	input logic valid,
	input logic flush,
	input logic mulw,
	input mul_op_pkg::mul_sign_t mul_signed,
	input logic [mul_cfg_pkg::xlen-1:0] mulcand,
	input logic [mul_cfg_pkg::xlen-1:0] muler,
	output logic ready,
	output logic out_valid,
	output logic [mul_cfg_pkg::xlen-1:0] result_hi,
	output logic [mul_cfg_pkg::xlen-1:0] result_lo
);

	// ************************************************************
	// two booth lanes side by side, one per multiplier half
	// ************************************************************
	booth_lane_if lane_lo_if ();
	booth_lane_if lane_hi_if ();

	// mulw flag as seen at acceptance
	logic word_op;

	mul_front front (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.flush(flush),
		.mulw(mulw),
		.mul_signed(mul_signed),
		.mulcand(mulcand),
		.muler(muler),
		.lo(lane_lo_if.front),
		.hi(lane_hi_if.front),
		.ready(ready),
		.word_op(word_op)
	);

	// low 32 multiplier bits
	booth_lane lane_lo (.clk(clk), .rst(rst), .bus(lane_lo_if.lane));
	// upper half with its sign
	booth_lane lane_hi (.clk(clk), .rst(rst), .bus(lane_hi_if.lane));

	product_combine combine (
		.clk(clk),
		.rst(rst),
		.lo(lane_lo_if.sink),
		.hi(lane_hi_if.sink),
		.word_op(word_op),
		.out_valid(out_valid),
		.result_hi(result_hi),
		.result_lo(result_lo)
	);

endmodule

`default_nettype wire

// File: design/mul_cfg_pkg.sv
`default_nettype none

package mul_cfg_pkg;

	// ************************************************************
	// operand and lane geometry
	// ************************************************************

	// one machine word
	localparam int unsigned xlen = 64;
	// each lane takes half of the multiplier
	localparam int unsigned half_w = 32;
	// multiplicand plus one extension bit
	localparam int unsigned mcand_w = xlen + 1;
	// multiplier half plus one extension bit
	localparam int unsigned mplier_w = half_w + 1;
	// 65 x 33 signed product
	localparam int unsigned part_w = mcand_w + mplier_w;
	// recoding window: appended zero below, spare sign bit above
	localparam int unsigned recode_w = mplier_w + 2;

	// radix-4 steps, two multiplier bits per step
	localparam int unsigned booth_steps = 17;
	localparam int unsigned step_cnt_w = 5;

endpackage

`default_nettype wire

// File: design/mul_front.sv
`default_nettype none

module mul_front (
	input logic clk,
	input logic rst,
	input logic valid,
	input logic flush,
	input logic mulw,
	input mul_op_pkg::mul_sign_t mul_signed,
	input logic [mul_cfg_pkg::xlen-1:0] mulcand,
	input logic [mul_cfg_pkg::xlen-1:0] muler,
	booth_lane_if.front lo,
	booth_lane_if.front hi,
	output logic ready,
	output logic word_op
);

	localparam int unsigned xlen = mul_cfg_pkg::xlen;
	localparam int unsigned half_w = mul_cfg_pkg::half_w;
	// load cycle + booth steps + combine cycle, counted from 0
	localparam logic [mul_cfg_pkg::step_cnt_w-1:0] last_cnt =
		mul_cfg_pkg::step_cnt_w'(mul_cfg_pkg::booth_steps + 1);

	logic busy;
	logic start_q;
	logic accept;
	logic [mul_cfg_pkg::step_cnt_w-1:0] cnt;
	logic a_sgn;
	logic b_sgn;
	logic [xlen-1:0] a_ext;
	logic [xlen-1:0] b_ext;
	logic [mul_cfg_pkg::mcand_w-1:0] mcand_q;
	logic [mul_cfg_pkg::mplier_w-1:0] mplier_lo_q;
	logic [mul_cfg_pkg::mplier_w-1:0] mplier_hi_q;

	assign ready = ~busy;
	// flush drops a request offered in the same cycle
	assign accept = valid & ready & ~flush;

	assign a_sgn = mul_signed[mul_op_pkg::mcand_sign_bit];
	assign b_sgn = mul_signed[mul_op_pkg::mplier_sign_bit];

	// word op: narrow both operands to their low words first
	always_comb begin
		a_ext = mulcand;
		b_ext = muler;
		if (mulw) begin
			a_ext = {{(xlen-half_w){a_sgn & mulcand[half_w-1]}}, mulcand[half_w-1:0]};
			b_ext = {{(xlen-half_w){b_sgn & muler[half_w-1]}}, muler[half_w-1:0]};
		end
	end

	// ************************************************************
	// busy tracking and step counter
	// ************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			start_q <= 1'b0;
			cnt <= '0;
			word_op <= 1'b0;
		end else begin
			start_q <= 1'b0;
			if (flush) begin
				busy <= 1'b0;
				cnt <= '0;
			end else if (accept) begin
				busy <= 1'b1;
				start_q <= 1'b1;
				cnt <= '0;
				word_op <= mulw;
			end else if (busy) begin
				// ready comes back with out_valid
				if (cnt == last_cnt)
					busy <= 1'b0;
				else
					cnt <= cnt + 1'b1;
			end
		end
	end

	// operand latches
	always_ff @(posedge clk) begin
		if (accept) begin
			mcand_q <= {a_sgn & a_ext[xlen-1], a_ext};
			// low half is always a plain magnitude
			mplier_lo_q <= {1'b0, b_ext[half_w-1:0]};
			mplier_hi_q <= {b_sgn & b_ext[xlen-1], b_ext[xlen-1:half_w]};
		end
	end

	assign lo.start = start_q;
	assign hi.start = start_q;
	assign lo.flush = flush;
	assign hi.flush = flush;
	// both lanes share the multiplicand
	assign lo.mcand = mcand_q;
	assign hi.mcand = mcand_q;
	assign lo.mplier = mplier_lo_q;
	assign hi.mplier = mplier_hi_q;

endmodule

`default_nettype wire

// File: design/mul_op_pkg.sv
`default_nettype none

package mul_op_pkg;

	// signedness field as the core encodes it
	// bit 1 -> multiplicand signed, bit 0 -> multiplier signed
	typedef logic [1:0] mul_sign_t;

	localparam int unsigned mcand_sign_bit = 1;
	localparam int unsigned mplier_sign_bit = 0;

	// ************************************************************
	// 128-bit product, read as doublewords or as a low word
	// ************************************************************
	typedef union packed {
		struct packed {
			logic [mul_cfg_pkg::xlen-1:0] hi;
			logic [mul_cfg_pkg::xlen-1:0] lo;
		} dword;
		// low word is all that mulw keeps
		struct packed {
			logic [2*mul_cfg_pkg::xlen-mul_cfg_pkg::half_w-1:0] upper;
			logic [mul_cfg_pkg::half_w-1:0] w;
		} word;
	} product_u;

endpackage

`default_nettype wire

// File: design/product_combine.sv
`default_nettype none

module product_combine (
	input logic clk,
	input logic rst,
	booth_lane_if.sink lo,
	booth_lane_if.sink hi,
	input logic word_op,
	output logic out_valid,
	output logic [mul_cfg_pkg::xlen-1:0] result_hi,
	output logic [mul_cfg_pkg::xlen-1:0] result_lo
);

	localparam int unsigned prod_w = 2 * mul_cfg_pkg::xlen;
	localparam int unsigned part_w = mul_cfg_pkg::part_w;
	localparam int unsigned half_w = mul_cfg_pkg::half_w;

	logic [prod_w-1:0] lo_ext;
	logic [prod_w-1:0] hi_ext;
	logic take;
	mul_op_pkg::product_u prod;

	// both partials are signed, extend before the add
	assign lo_ext = {{(prod_w-part_w){lo.partial[part_w-1]}}, lo.partial};
	assign hi_ext = {{(prod_w-part_w){hi.partial[part_w-1]}}, hi.partial};
	// high lane carries weight 2^32, wrap at 128 bits
	assign prod = lo_ext + (hi_ext << half_w);

	// lanes finish together; a late flush still kills the result
	assign take = lo.done & hi.done & ~lo.flush;

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= take;
	end

	// results hold until the next one
	always_ff @(posedge clk) begin
		if (take) begin
			result_hi <= prod.dword.hi;
			if (word_op)
				result_lo <= {{(mul_cfg_pkg::xlen-half_w){prod.word.w[half_w-1]}}, prod.word.w};
			else
				result_lo <= prod.dword.lo;
		end
	end

endmodule

`default_nettype wire

// File: dv/mul_checker.sv
`default_nettype none

module mul_checker (
	input logic clk,
	input logic rst,
	input logic valid,
	input logic flush,
	input logic mulw,
	input mul_op_pkg::mul_sign_t mul_signed,
	input logic [mul_cfg_pkg::xlen-1:0] mulcand,
	input logic [mul_cfg_pkg::xlen-1:0] muler,
	input logic ready,
	input logic out_valid,
	input logic [mul_cfg_pkg::xlen-1:0] result_hi,
	input logic [mul_cfg_pkg::xlen-1:0] result_lo
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned xlen = mul_cfg_pkg::xlen;
	localparam int unsigned half_w = mul_cfg_pkg::half_w;
	// rising edges from acceptance to out_valid
	localparam int unsigned latency = mul_cfg_pkg::booth_steps + 2;

	int unsigned value_errors = 0;
	int unsigned event_errors = 0;
	int unsigned results_seen = 0;

	// model state for the one request in flight
	logic in_flight = 1'b0;
	int unsigned age = 0;
	logic exp_word = 1'b0;
	logic [2*xlen-1:0] exp_prod = '0;

	// mulw narrows first, then sign or zero extension to 129 bits
	function automatic logic [2*xlen:0] extend_operand(logic [xlen-1:0] v, logic sgn,
		logic word);
		logic [xlen-1:0] w;
		w = v;
		if (word)
			w = {{(xlen-half_w){sgn & v[half_w-1]}}, v[half_w-1:0]};
		return {{(xlen+1){sgn & w[xlen-1]}}, w};
	endfunction

	task automatic compare_value(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// ************************************************************
	// sampled mid-cycle where inputs and outputs are settled
	// ************************************************************
	always @(negedge clk) begin
		logic exp_ov;
		logic exp_ready;
		logic [2*xlen:0] a_x;
		logic [2*xlen:0] b_x;
		logic [2*xlen:0] p;
		if (rst) begin
			in_flight = 1'b0;
			age = 0;
		end else begin
			exp_ov = in_flight && age == latency;
			// ready comes back with out_valid
			exp_ready = !in_flight || age == latency;
			if (ready !== exp_ready) begin
				value_errors++;
				$display("FAILED t=%0t ready expected %b got %b", $time, exp_ready, ready);
			end
			if (out_valid !== exp_ov) begin
				event_errors++;
				if (exp_ov)
					$display("no out_valid %0d edges after acceptance, at %0t", latency, $time);
				else
					$display("out_valid with no request due, at %0t", $time);
			end
			if (exp_ov && out_valid === 1'b1) begin
				results_seen++;
				if (exp_word) begin
					compare_value("result_lo",
						result_lo, {{(xlen-half_w){exp_prod[half_w-1]}}, exp_prod[half_w-1:0]});
				end else begin
					compare_value("result_hi", result_hi, exp_prod[2*xlen-1:xlen]);
					compare_value("result_lo", result_lo, exp_prod[xlen-1:0]);
				end
			end
			// advance to the next edge
			if (exp_ov)
				in_flight = 1'b0;
			else if (in_flight && flush)
				in_flight = 1'b0;
			else if (in_flight)
				age++;
			if (exp_ready && valid && !flush) begin
				a_x = extend_operand(mulcand, mul_signed[mul_op_pkg::mcand_sign_bit], mulw);
				b_x = extend_operand(muler, mul_signed[mul_op_pkg::mplier_sign_bit], mulw);
				p = a_x * b_x;
				exp_prod = p[2*xlen-1:0];
				exp_word = mulw;
				in_flight = 1'b1;
				// edges counted from the accepting one
				age = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/mul_props.sv
`default_nettype none

module mul_props (
	input logic clk,
	input logic rst,
	input logic valid,
	input logic flush,
	input logic ready,
	input logic out_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned quiet_len = mul_cfg_pkg::booth_steps + 2;

	int unsigned fail_count = 0;
	logic accept;
	// cycles left in which a flushed request must stay silent
	logic [4:0] quiet;

	assign accept = valid & ready & ~flush;

	always_ff @(posedge clk) begin
		if (rst)
			quiet <= '0;
		else if (flush)
			quiet <= 5'(quiet_len);
		else if (accept)
			// newer request, its result is legal again
			quiet <= '0;
		else if (quiet != 5'd0)
			quiet <= quiet - 5'd1;
	end

	// ************************************************************
	// handshake and flush properties
	// ************************************************************
	single_pulse: assert property (@(posedge clk) disable iff (rst) out_valid |=> !out_valid)
		else begin
			fail_count++;
			$error("out_valid high in two consecutive cycles");
		end

	busy_after_accept: assert property (@(posedge clk) disable iff (rst) accept |=> !ready)
		else begin
			fail_count++;
			$error("ready still high in the cycle after an acceptance");
		end

	silent_after_flush: assert property (@(posedge clk) disable iff (rst)
		(quiet != 5'd0) |-> !out_valid)
		else begin
			fail_count++;
			$error("out_valid for a request that was flushed");
		end

endmodule

bind booth_multiplier mul_props props (
	.clk(clk),
	.rst(rst),
	.valid(valid),
	.flush(flush),
	.ready(ready),
	.out_valid(out_valid)
);

`default_nettype wire

// File: dv/tb_booth_multiplier.sv
`default_nettype none

module tb_booth_multiplier;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned xlen = mul_cfg_pkg::xlen;
	localparam int unsigned n_requests = 400;
	localparam int unsigned ready_timeout = 40;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic valid = 1'b0;
	logic flush = 1'b0;
	logic mulw = 1'b0;
	mul_op_pkg::mul_sign_t mul_signed = '0;
	logic [xlen-1:0] mulcand = '0;
	logic [xlen-1:0] muler = '0;
	logic ready;
	logic out_valid;
	logic [xlen-1:0] result_hi;
	logic [xlen-1:0] result_lo;

	logic [31:0] rng = 32'hece5;
	int unsigned timeouts = 0;

	// 20 ns period
	always #10 clk = ~clk;

	booth_multiplier uut (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.flush(flush),
		.mulw(mulw),
		.mul_signed(mul_signed),
		.mulcand(mulcand),
		.muler(muler),
		.ready(ready),
		.out_valid(out_valid),
		.result_hi(result_hi),
		.result_lo(result_lo)
	);

	// watches the same pins and does all the comparing
	mul_checker chk (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.flush(flush),
		.mulw(mulw),
		.mul_signed(mul_signed),
		.mulcand(mulcand),
		.muler(muler),
		.ready(ready),
		.out_valid(out_valid),
		.result_hi(result_hi),
		.result_lo(result_lo)
	);

	// ************************************************************
	// random source and stimulus tasks
	// ************************************************************
	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng = xorshift32(rng);
		r = rng;
	endtask

	// corner values now and then, otherwise plain random
	task automatic pick_operand(output logic [xlen-1:0] v);
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		next_random(r0);
		next_random(r1);
		next_random(r2);
		case (r0[3:0])
			4'd0: v = '1;
			4'd1: v = {1'b1, {(xlen-1){1'b0}}};
			4'd2: v = '0;
			// small negative
			4'd3: v = {{32{1'b1}}, r1};
			default: v = {r1, r2};
		endcase
	endtask

	// inputs change 1 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_ready();
		int unsigned n;
		n = 0;
		while (ready !== 1'b1 && n < ready_timeout) begin
			next_cycle();
			n++;
		end
		if (ready !== 1'b1) begin
			timeouts++;
			$display("ready stayed low for %0d cycles, gave up at %0t", ready_timeout, $time);
		end
	endtask

	task automatic drive_request();
		logic [31:0] r;
		next_random(r);
		pick_operand(mulcand);
		pick_operand(muler);
		// word op about 1 in 4
		mulw = (r[1:0] == 2'd0);
		mul_signed = r[3:2];
		valid = 1'b1;
		next_cycle();
		// valid kept up while busy, must be ignored
		repeat (r[5:4]) begin
			pick_operand(mulcand);
			next_cycle();
		end
		valid = 1'b0;
		// flush about 1 in 16, sometimes with a request that gets dropped
		if (r[11:8] == 4'd0) begin
			repeat (r[16:12]) next_cycle();
			flush = 1'b1;
			valid = r[17];
			next_cycle();
			flush = 1'b0;
			valid = 1'b0;
		end
		repeat (r[19:18]) next_cycle();
	endtask

	// ************************************************************
	// main sequence
	// ************************************************************
	initial begin
		int unsigned total;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < n_requests && timeouts == 0; i++) begin
			wait_ready();
			if (timeouts == 0)
				drive_request();
		end
		// let the last result come out
		wait_ready();
		repeat (2) next_cycle();
		total = chk.value_errors + chk.event_errors + timeouts + uut.props.fail_count;
		$display("results %0d, value errors %0d, event errors %0d, timeouts %0d, assertion errors %0d",
			chk.results_seen, chk.value_errors, chk.event_errors, timeouts,
			uut.props.fail_count);
		if (total == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the booth multiplier testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

top=tb_booth_multiplier
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module "$top" -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion errors so the testbench prints its verdict
./obj_dir/V$top +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$log"; then
	exit 1
fi
exit 0

// File: tb.f
design/mul_cfg_pkg.sv
design/mul_op_pkg.sv
design/booth_lane_if.sv
design/mul_front.sv
design/booth_lane.sv
design/product_combine.sv
design/booth_multiplier.sv
dv/mul_props.sv
dv/mul_checker.sv
dv/tb_booth_multiplier.sv
